// File: common/isa_pkg.sv
// Operation set and data width; op codes above op_mul_hi are unused and decode to nothing
`default_nettype none

package isa_pkg;

    // Operand and result width
    localparam int DATA_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // ALU class first, multiply class last
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul_lo,   // low half of unsigned product
        op_mul_hi    // high half of unsigned product
    } op_t;

endpackage

`default_nettype wire

// File: common/uarch_pkg.sv
// Core sizing; tags are reused only after broadcast, MULT_STAGES must be 2 or more
`default_nettype none

package uarch_pkg;

    // Destination tag width, 16 results in flight at most
    localparam int TAG_WIDTH = 4;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Default station depths, passed down from the top level
    localparam int ALU_ENTRIES  = 4;
    localparam int MULT_ENTRIES = 2;

    // Multiplier depth from issue to result register
    localparam int MULT_STAGES = 3;

    // CDB arbiter priority on a conflict
    typedef enum logic {
        pref_alu,
        pref_mult
    } cdb_pref_t;

endpackage

`default_nettype wire

// File: common/dispatch_if.sv
// Dispatch strobe bundle, one-cycle valid with no back-pressure toward the source
`timescale 1ns/10ps
`default_nettype none

interface dispatch_if;
    import isa_pkg::*;
    import uarch_pkg::*;

    logic  valid;
    op_t   op;
    tag_t  dest_tag;
    // Each source is either a value or the tag it waits on
    logic  src1_ready;
    data_t src1_value;
    tag_t  src1_tag;
    logic  src2_ready;
    data_t src2_value;
    tag_t  src2_tag;

    modport sink (
        input valid, op, dest_tag,
        input src1_ready, src1_value, src1_tag,
        input src2_ready, src2_value, src2_tag
    );

endinterface

`default_nettype wire

// File: common/issue_if.sv
// Station to unit handshake; transfer on valid and ready, fields held stable until then
`timescale 1ns/10ps
`default_nettype none

interface issue_if;
    import isa_pkg::*;
    import uarch_pkg::*;

    logic  valid;
    logic  ready;
    op_t   op;
    tag_t  dest_tag;
    data_t a;
    data_t b;

    modport station (output valid, op, dest_tag, a, b, input ready);
    modport unit    (input valid, op, dest_tag, a, b, output ready);

endinterface

`default_nettype wire

// File: common/result_if.sv
// Result register to CDB arbiter; source holds until grant, grant only while valid
`timescale 1ns/10ps
`default_nettype none

interface result_if;
    import isa_pkg::*;
    import uarch_pkg::*;

    logic  valid;
    tag_t  tag;
    data_t value;
    logic  grant;

    modport source  (output valid, tag, value, input grant);
    modport arbiter (input valid, tag, value, output grant);

endinterface

`default_nettype wire

// File: station/reservation_station.sv
// Lowest-index select, not oldest; a dispatch arriving while full is dropped silently
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int ENTRIES = 4
) (
    input  logic            clock,
    input  logic            reset,
    dispatch_if.sink        dispatch,
    input  logic            accept,
    input  logic            cdb_valid,
    input  uarch_pkg::tag_t cdb_tag,
    input  isa_pkg::data_t  cdb_value,
    issue_if.station        issue,
    output logic            full
);
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int IDX_WIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    // Entry state
    logic [ENTRIES-1:0] busy;
    logic [ENTRIES-1:0] rdy1;
    logic [ENTRIES-1:0] rdy2;
    op_t                op_q   [ENTRIES];
    tag_t               dest_q [ENTRIES];
    data_t              val1   [ENTRIES];
    data_t              val2   [ENTRIES];
    tag_t               tag1   [ENTRIES];
    tag_t               tag2   [ENTRIES];

    logic [IDX_WIDTH-1:0] free_idx;
    logic [IDX_WIDTH-1:0] sel_idx;
    logic                 sel_found;
    logic                 write_en;
    logic                 take;
    logic                 wake1_new;
    logic                 wake2_new;

    //////////////////////////////////////////////////
    // Free and ready select
    //////////////////////////////////////////////////

    // Scan downward so the lowest match wins
    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = IDX_WIDTH'(i);
            end
            if (busy[i] && rdy1[i] && rdy2[i]) begin
                sel_idx   = IDX_WIDTH'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign full     = &busy;
    assign write_en = dispatch.valid && accept && !full;
    assign take     = issue.valid && issue.ready;

    // Source captured straight off the CDB on the dispatch edge
    assign wake1_new = cdb_valid && !dispatch.src1_ready && (dispatch.src1_tag == cdb_tag);
    assign wake2_new = cdb_valid && !dispatch.src2_ready && (dispatch.src2_tag == cdb_tag);

    assign issue.valid    = sel_found;
    assign issue.op       = op_q[sel_idx];
    assign issue.dest_tag = dest_q[sel_idx];
    assign issue.a        = val1[sel_idx];
    assign issue.b        = val2[sel_idx];

    //////////////////////////////////////////////////
    // Entry update
    //////////////////////////////////////////////////

    // Write and take never hit the same entry
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (take) begin
                busy[sel_idx] <= 1'b0;
            end
            if (write_en) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (write_en && (free_idx == IDX_WIDTH'(i))) begin
                op_q[i]   <= dispatch.op;
                dest_q[i] <= dispatch.dest_tag;
                rdy1[i]   <= dispatch.src1_ready || wake1_new;
                val1[i]   <= wake1_new ? cdb_value : dispatch.src1_value;
                tag1[i]   <= dispatch.src1_tag;
                rdy2[i]   <= dispatch.src2_ready || wake2_new;
                val2[i]   <= wake2_new ? cdb_value : dispatch.src2_value;
                tag2[i]   <= dispatch.src2_tag;
            end else if (busy[i] && cdb_valid) begin
                // Wakeup of waiting sources
                if (!rdy1[i] && (tag1[i] == cdb_tag)) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= cdb_value;
                end
                if (!rdy2[i] && (tag2[i] == cdb_tag)) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= cdb_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu_cluster.sv
// Single-cycle ALU cluster; results wrap at 16 bits, no flags or overflow reported
`timescale 1ns/10ps
`default_nettype none

module alu_cluster #(
    parameter int ENTRIES = 4
) (
    input  logic            clock,
    input  logic            reset,
    dispatch_if.sink        dispatch,
    input  logic            cdb_valid,
    input  uarch_pkg::tag_t cdb_tag,
    input  isa_pkg::data_t  cdb_value,
    result_if.source        result,
    output logic            full
);
    import isa_pkg::*;

    issue_if alu_issue ();

    logic  accept;
    data_t alu_out;

    // ALU op class only
    assign accept = dispatch.op inside {op_add, op_sub, op_and, op_xor};

    reservation_station #(
        .ENTRIES (ENTRIES)
    ) u_station (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (dispatch),
        .accept    (accept),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .issue     (alu_issue),
        .full      (full)
    );

    always_comb begin
        case (alu_issue.op)
            op_add:  alu_out = alu_issue.a + alu_issue.b;
            op_sub:  alu_out = alu_issue.a - alu_issue.b;
            op_and:  alu_out = alu_issue.a & alu_issue.b;
            op_xor:  alu_out = alu_issue.a ^ alu_issue.b;
            default: alu_out = '0;
        endcase
    end

    // Free to issue when the result slot is empty or leaving this edge
    assign alu_issue.ready = !result.valid || result.grant;

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (alu_issue.valid && alu_issue.ready) begin
            result.valid <= 1'b1;
        end else if (result.grant) begin
            result.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue.valid && alu_issue.ready) begin
            result.tag   <= alu_issue.dest_tag;
            result.value <= alu_out;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mult_cluster.sv
// Unsigned 16x16 multiplier cluster; whole pipe stalls on an ungranted result, MULT_STAGES >= 2
`timescale 1ns/10ps
`default_nettype none

module mult_cluster #(
    parameter int ENTRIES = 2
) (
    input  logic            clock,
    input  logic            reset,
    dispatch_if.sink        dispatch,
    input  logic            cdb_valid,
    input  uarch_pkg::tag_t cdb_tag,
    input  isa_pkg::data_t  cdb_value,
    result_if.source        result,
    output logic            full
);
    import isa_pkg::*;
    import uarch_pkg::*;

    // Registers between issue and the result register
    localparam int PIPE_REGS = MULT_STAGES - 1;
    localparam int LAST      = PIPE_REGS - 1;

    // Full-width unsigned product
    typedef logic [2*DATA_WIDTH-1:0] product_t;

    issue_if mult_issue ();

    logic     accept;
    logic     stall;
    data_t    half;
    logic     pipe_valid [PIPE_REGS];
    tag_t     pipe_tag   [PIPE_REGS];
    logic     pipe_hi    [PIPE_REGS];
    product_t pipe_prod  [PIPE_REGS];

    assign accept = dispatch.op inside {op_mul_lo, op_mul_hi};

    reservation_station #(
        .ENTRIES (ENTRIES)
    ) u_station (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (dispatch),
        .accept    (accept),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .issue     (mult_issue),
        .full      (full)
    );

    // Held result blocks every stage, and issue with it
    assign stall            = result.valid && !result.grant;
    assign mult_issue.ready = !stall;

    // Last stage picks the requested half
    assign half = pipe_hi[LAST] ? pipe_prod[LAST][2*DATA_WIDTH-1:DATA_WIDTH]
                                : pipe_prod[LAST][DATA_WIDTH-1:0];

    //////////////////////////////////////////////////
    // Pipeline and result register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PIPE_REGS; i++) begin
                pipe_valid[i] <= 1'b0;
            end
            result.valid <= 1'b0;
        end else if (!stall) begin
            pipe_valid[0] <= mult_issue.valid;
            for (int i = 1; i < PIPE_REGS; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
            result.valid <= pipe_valid[LAST];
        end
    end

    // Product formed in the first stage, then carried with its tag
    always_ff @(posedge clock) begin
        if (!stall) begin
            pipe_tag[0]  <= mult_issue.dest_tag;
            pipe_hi[0]   <= (mult_issue.op == op_mul_hi);
            pipe_prod[0] <= product_t'(mult_issue.a) * product_t'(mult_issue.b);
            for (int i = 1; i < PIPE_REGS; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_hi[i]   <= pipe_hi[i-1];
                pipe_prod[i] <= pipe_prod[i-1];
            end
            result.tag   <= pipe_tag[LAST];
            result.value <= half;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cdb_arbiter.sv
// Two-way round-robin onto one CDB slot; broadcast is registered, one result per cycle
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic            clock,
    input  logic            reset,
    result_if.arbiter       alu_result,
    result_if.arbiter       mult_result,
    output logic            cdb_valid,
    output uarch_pkg::tag_t cdb_tag,
    output isa_pkg::data_t  cdb_value
);
    import uarch_pkg::*;

    cdb_pref_t pref;
    logic      conflict;

    assign conflict = alu_result.valid && mult_result.valid;

    // Lone requester wins, otherwise the preferred side
    assign alu_result.grant  = alu_result.valid && (!mult_result.valid || pref == pref_alu);
    assign mult_result.grant = mult_result.valid && (!alu_result.valid || pref == pref_mult);

    // Priority turns over only after a conflict
    always_ff @(posedge clock) begin
        if (reset) begin
            pref      <= pref_alu;
            cdb_valid <= 1'b0;
        end else begin
            if (conflict) begin
                pref <= (pref == pref_alu) ? pref_mult : pref_alu;
            end
            cdb_valid <= alu_result.grant || mult_result.grant;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_result.grant) begin
            cdb_tag   <= alu_result.tag;
            cdb_value <= alu_result.value;
        end else if (mult_result.grant) begin
            cdb_tag   <= mult_result.tag;
            cdb_value <= mult_result.value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/issue_core.sv
// Issue back end top; source must not dispatch to a full station or reuse a live tag
`timescale 1ns/10ps
`default_nettype none

module issue_core (
    input  logic            clock,
    input  logic            reset,
    input  logic            dispatch_valid,
    input  isa_pkg::op_t    dispatch_op,
    input  uarch_pkg::tag_t dispatch_tag,
    input  logic            src1_ready,
    input  logic            src2_ready,
    input  isa_pkg::data_t  src1_value,
    input  isa_pkg::data_t  src2_value,
    input  uarch_pkg::tag_t src1_tag,
    input  uarch_pkg::tag_t src2_tag,
    output logic            alu_full,
    output logic            mult_full,
    output logic            cdb_valid,
    output uarch_pkg::tag_t cdb_tag,
    output isa_pkg::data_t  cdb_value
);
    import uarch_pkg::*;

    dispatch_if disp ();
    result_if   alu_res ();
    result_if   mult_res ();

    // Dispatch fans out to both clusters
    assign disp.valid      = dispatch_valid;
    assign disp.op         = dispatch_op;
    assign disp.dest_tag   = dispatch_tag;
    assign disp.src1_ready = src1_ready;
    assign disp.src1_value = src1_value;
    assign disp.src1_tag   = src1_tag;
    assign disp.src2_ready = src2_ready;
    assign disp.src2_value = src2_value;
    assign disp.src2_tag   = src2_tag;

    alu_cluster #(
        .ENTRIES (ALU_ENTRIES)
    ) u_alu (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (disp),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .result    (alu_res),
        .full      (alu_full)
    );

    mult_cluster #(
        .ENTRIES (MULT_ENTRIES)
    ) u_mult (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (disp),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .result    (mult_res),
        .full      (mult_full)
    );

    // Broadcast also feeds station wakeup
    cdb_arbiter u_arbiter (
        .clock       (clock),
        .reset       (reset),
        .alu_result  (alu_res),
        .mult_result (mult_res),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

`default_nettype wire

// File: tb/issue_core_chk.sv
// Bound into issue_core; flags source-side rule breaks and a CDB that moves before any dispatch
`timescale 1ns/10ps
`default_nettype none

module issue_core_chk (
    input logic            clock,
    input logic            reset,
    input logic            dispatch_valid,
    input isa_pkg::op_t    dispatch_op,
    input logic            alu_full,
    input logic            mult_full,
    input logic            cdb_valid,
    input uarch_pkg::tag_t cdb_tag,
    input isa_pkg::data_t  cdb_value
);
    import isa_pkg::*;

    logic is_alu_op;
    logic is_mult_op;
    logic dispatched;

    assign is_alu_op  = dispatch_op inside {op_add, op_sub, op_and, op_xor};
    assign is_mult_op = dispatch_op inside {op_mul_lo, op_mul_hi};

    // Set by the first dispatch after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            dispatched <= 1'b0;
        end else if (dispatch_valid) begin
            dispatched <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////

    alu_not_full: assert property (@(posedge clock) disable iff (reset)
        (dispatch_valid && is_alu_op) |-> !alu_full)
        else $error("ALU op dispatched into a full ALU station");

    mult_not_full: assert property (@(posedge clock) disable iff (reset)
        (dispatch_valid && is_mult_op) |-> !mult_full)
        else $error("multiply op dispatched into a full multiply station");

    cdb_known: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> !$isunknown({cdb_tag, cdb_value}))
        else $error("CDB tag or value unknown during a broadcast");

    // Nothing can reach the CDB before something was dispatched
    quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
        !dispatched |-> !cdb_valid)
        else $error("CDB broadcast seen before the first dispatch");

endmodule

`default_nettype wire

// File: tb/issue_core_tb.sv
// Directed tests for issue_core; stimulus never targets a full station or reuses a live tag
`timescale 1ns/10ps
`default_nettype none

module issue_core_tb;
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int CYCLE_LIMIT = 4000;
    localparam int WAIT_LIMIT  = 200;
    localparam int TAGS        = 2 ** TAG_WIDTH;
    localparam int RANDOM_SEED = 32'h1827_4c14;

    logic  clock;
    logic  reset;
    logic  dispatch_valid;
    op_t   dispatch_op;
    tag_t  dispatch_tag;
    logic  src1_ready;
    logic  src2_ready;
    data_t src1_value;
    data_t src2_value;
    tag_t  src1_tag;
    tag_t  src2_tag;
    logic  alu_full;
    logic  mult_full;
    logic  cdb_valid;
    tag_t  cdb_tag;
    data_t cdb_value;

    // Scoreboard by tag; a tag is live while issued and seen differ
    data_t expected     [TAGS];
    int    issued_count [TAGS];
    int    seen_count   [TAGS];
    int    cycle_count = 0;

    issue_core UUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .src1_value     (src1_value),
        .src2_value     (src2_value),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .alu_full       (alu_full),
        .mult_full      (mult_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    bind issue_core issue_core_chk u_chk (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .alu_full       (alu_full),
        .mult_full      (mult_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    // Op rules: 16-bit wrap for ALU ops, halves of the unsigned 32-bit product
    function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
        logic [31:0] product;
        product = {16'h0000, a} * {16'h0000, b};
        case (op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_and:    return a & b;
            op_xor:    return a ^ b;
            op_mul_lo: return product[15:0];
            op_mul_hi: return product[31:16];
            default:   return '0;
        endcase
    endfunction

    function automatic logic station_full(input op_t op);
        return (op == op_mul_lo || op == op_mul_hi) ? mult_full : alu_full;
    endfunction

    function automatic logic outstanding(input tag_t tag);
        return issued_count[tag] != seen_count[tag];
    endfunction

    function automatic logic any_outstanding();
        for (int t = 0; t < TAGS; t++) begin
            if (outstanding(tag_t'(t))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic next_cycle;
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    // Called on a falling edge; the strobe is held for one rising edge
    task automatic send_op(input op_t op, input tag_t tag,
                           input logic r1, input data_t v1, input tag_t t1,
                           input logic r2, input data_t v2, input tag_t t2);
        data_t a;
        data_t b;
        while (station_full(op)) begin
            next_cycle();
        end
        // Waiting sources take the producer's expected value
        a = r1 ? v1 : expected[t1];
        b = r2 ? v2 : expected[t2];
        expected[tag]     = model_result(op, a, b);
        issued_count[tag] = issued_count[tag] + 1;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag   = tag;
        src1_ready     = r1;
        src1_value     = v1;
        src1_tag       = t1;
        src2_ready     = r2;
        src2_value     = v2;
        src2_tag       = t2;
        next_cycle();
    endtask

    task automatic send_ready(input op_t op, input tag_t tag, input data_t a, input data_t b);
        send_op(op, tag, 1'b1, a, '0, 1'b1, b, '0);
    endtask

    task automatic wait_all_seen(input string name);
        int n;
        n = 0;
        while (any_outstanding() && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (!any_outstanding())
        else fail_run($sformatf("%s: results still missing after %0d cycles", name, n));
    endtask

    //////////////////////////////////////////////////
    // Monitor and timeout
    //////////////////////////////////////////////////

    // Outputs are registered, so mid-cycle sampling sees each broadcast once
    always @(negedge clock) begin
        if (reset) begin
            for (int t = 0; t < TAGS; t++) begin
                seen_count[t] <= 0;
            end
        end else if (cdb_valid) begin
            assert (issued_count[cdb_tag] == seen_count[cdb_tag] + 1)
            else fail_run($sformatf("tag %0d was broadcast at %0t with no result outstanding",
                                    cdb_tag, $time));
            assert (cdb_value == expected[cdb_tag])
            else fail_run($sformatf("mismatch at %0t: tag %0d value %h, expected %h",
                                    $time, cdb_tag, cdb_value, expected[cdb_tag]));
            seen_count[cdb_tag] <= seen_count[cdb_tag] + 1;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_idle;
        repeat (10) begin
            assert (!cdb_valid && !alu_full && !mult_full)
            else fail_run($sformatf("mismatch at %0t: outputs not idle after reset", $time));
            @(negedge clock);
        end
    endtask

    task automatic alu_ops;
        // Wrap cases first
        send_ready(op_add, 4'd0, 16'hffff, 16'h0002);
        send_ready(op_add, 4'd1, 16'h1234, 16'h4321);
        send_ready(op_sub, 4'd2, 16'h0000, 16'h0001);
        send_ready(op_sub, 4'd3, 16'h8000, 16'h7fff);
        send_ready(op_and, 4'd4, 16'hf0f0, 16'h3c3c);
        send_ready(op_xor, 4'd5, 16'ha5a5, 16'hffff);
        for (int i = 6; i < 12; i++) begin
            send_ready(op_t'($urandom_range(3, 0)), tag_t'(i), data_t'($urandom),
                       data_t'($urandom));
        end
        wait_all_seen("alu ops");
    endtask

    task automatic mult_ops;
        // Back to back, several products in the pipe together
        send_ready(op_mul_lo, 4'd0, 16'hffff, 16'hffff);
        send_ready(op_mul_hi, 4'd1, 16'hffff, 16'hffff);
        send_ready(op_mul_hi, 4'd2, 16'h1234, 16'h5678);
        send_ready(op_mul_lo, 4'd3, 16'h1234, 16'h5678);
        for (int i = 4; i < 10; i++) begin
            send_ready(op_t'($urandom_range(5, 4)), tag_t'(i), data_t'($urandom),
                       data_t'($urandom));
        end
        wait_all_seen("multiply ops");
    endtask

    task automatic dependent_chain;
        op_t chain_ops [8];
        int  n;
        chain_ops = '{op_add, op_mul_lo, op_xor, op_sub, op_mul_hi, op_and, op_mul_lo, op_add};
        send_ready(chain_ops[0], 4'd0, data_t'($urandom), data_t'($urandom));
        for (int k = 1; k < 8; k++) begin
            // Even links catch their producer on the CDB in the dispatch cycle
            if (k % 2 == 0) begin
                n = 0;
                while (!(cdb_valid && cdb_tag == tag_t'(k - 1)) && n < WAIT_LIMIT) begin
                    @(negedge clock);
                    n++;
                end
                assert (n < WAIT_LIMIT)
                else fail_run($sformatf("chain producer tag %0d never reached the CDB", k - 1));
            end
            // Waiting source swaps every two links, so both sources see both wakeup paths
            if ((k / 2) % 2 == 0) begin
                send_op(chain_ops[k], tag_t'(k), 1'b0, '0, tag_t'(k - 1),
                        1'b1, data_t'($urandom), '0);
            end else begin
                send_op(chain_ops[k], tag_t'(k), 1'b1, data_t'($urandom), '0,
                        1'b0, '0, tag_t'(k - 1));
            end
        end
        wait_all_seen("dependent chain");
    endtask

    task automatic alu_fill;
        tag_t  producer;
        data_t x;
        data_t y;
        producer = 4'd9;
        x = data_t'($urandom);
        y = data_t'($urandom);
        // Producer value known ahead of its dispatch
        expected[producer] = model_result(op_mul_lo, x, y);
        for (int i = 0; i < ALU_ENTRIES; i++) begin
            assert (!alu_full)
            else fail_run($sformatf("mismatch at %0t: alu_full high after %0d dispatches",
                                    $time, i));
            send_op(op_t'(i % 4), tag_t'(i), 1'b0, '0, producer, 1'b1, data_t'($urandom), '0);
        end
        assert (alu_full)
        else fail_run($sformatf("mismatch at %0t: alu_full low with every entry waiting", $time));
        send_ready(op_mul_lo, producer, x, y);
        wait_all_seen("alu fill");
    endtask

    task automatic random_mix;
        tag_t tag;
        tag_t start;
        op_t  op;
        for (int i = 0; i < 60; i++) begin
            op    = op_t'($urandom_range(5, 0));
            tag   = tag_t'($urandom);
            start = tag;
            // Next tag whose last use has been broadcast
            while (outstanding(tag)) begin
                tag = tag + 1'b1;
                if (tag == start) begin
                    next_cycle();
                end
            end
            send_ready(op, tag, data_t'($urandom), data_t'($urandom));
        end
        wait_all_seen("random mix");
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(RANDOM_SEED));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = op_add;
        dispatch_tag   = '0;
        src1_ready     = 1'b0;
        src2_ready     = 1'b0;
        src1_value     = '0;
        src2_value     = '0;
        src1_tag       = '0;
        src2_tag       = '0;
        for (int t = 0; t < TAGS; t++) begin
            issued_count[t] = 0;
            expected[t]     = '0;
        end
        repeat (2) @(negedge clock);
        reset = 1'b0;
        reset_idle();
        alu_ops();
        mult_ops();
        dependent_chain();
        alu_fill();
        random_mix();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/isa_pkg.sv
common/uarch_pkg.sv
common/dispatch_if.sv
common/issue_if.sv
common/result_if.sv
station/reservation_station.sv
hdl/alu_cluster.sv
hdl/mult_cluster.sv
hdl/cdb_arbiter.sv
hdl/issue_core.sv
tb/issue_core_chk.sv
tb/issue_core_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = issue_core_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
